/* ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

`define OOO_XLEN        32             // integer data width.
`define OOO_NUM_ARCH    32             // architectural registers.
`define OOO_NUM_PHYS    256            // physical registers.
`define OOO_PHYS_W      8              // physical register tag width.
`define OOO_MUL_STAGES  3              // multiplier latency in cycles.
`define OOO_MEM_WORDS   256            // words in the load memory.
`define OOO_MEM_HASH    32'h9E3779B1   // word k of the load memory holds k times this.

`endif

/* ooo_pkg.sv */
`include "ooo_defines.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MUL  = 3'd2,
        OP_DIV  = 3'd3,
        OP_LOAD = 3'd4
    } op_e;

    typedef struct packed {
        op_e         opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [13:0] unused;
    } r_fmt_t;

    typedef struct packed {
        op_e                opcode;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic signed [18:0] imm;
    } i_fmt_t;

    // opcode, rd and rs1 sit in the same bits in both formats.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        op_e                    op;
        logic [7:0]             seq;
        logic [4:0]             rd;
        logic [`OOO_PHYS_W-1:0] pd;
        logic [`OOO_PHYS_W-1:0] old_pd;
        logic [`OOO_PHYS_W-1:0] ps1;
        logic [`OOO_PHYS_W-1:0] ps2;
        logic [`OOO_XLEN-1:0]   imm;
    } renamed_t;

    typedef struct packed {
        logic [7:0]             seq;
        logic [4:0]             rd;
        logic [`OOO_PHYS_W-1:0] pd;
        logic [`OOO_XLEN-1:0]   a;
        logic [`OOO_XLEN-1:0]   b;
    } fu_req_t;

    typedef struct packed {
        logic                   valid;
        logic [7:0]             seq;
        logic [4:0]             rd;
        logic [`OOO_PHYS_W-1:0] pd;
        logic [`OOO_XLEN-1:0]   data;
    } wb_t;

    localparam int FU_ADD  = 0;
    localparam int FU_LOAD = 1;
    localparam int FU_MUL  = 2;
    localparam int FU_DIV  = 3;

endpackage

/* rename_unit.sv */
`timescale 1ns/100ps
`include "ooo_defines.svh"

module rename_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  ooo_pkg::instr_u        instr,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    output ooo_pkg::renamed_t      ren,
    output logic                   ren_valid,
    input  logic                   ren_ready,
    output logic                   mark_valid,
    output logic [`OOO_PHYS_W-1:0] mark_pd,
    input  logic                   free_valid,
    input  logic [`OOO_PHYS_W-1:0] free_pd
);
    import ooo_pkg::*;

    localparam int PHYS_W    = `OOO_PHYS_W;
    localparam int NUM_FREE  = `OOO_NUM_PHYS - `OOO_NUM_ARCH;

    logic [PHYS_W-1:0] map_table [`OOO_NUM_ARCH];
    logic [PHYS_W-1:0] free_list [`OOO_NUM_PHYS];
    logic [PHYS_W-1:0] head;
    logic [PHYS_W-1:0] tail;
    logic [PHYS_W:0]   count;
    logic [7:0]        seq;
    logic              accept;
    logic              pop;
    logic              is_load;

    assign instr_ready = (count != '0) && (!ren_valid || ren_ready);
    assign accept      = instr_valid && instr_ready;
    assign pop         = accept && (instr.r_fmt.rd != '0);   // r0 never gets a new register.
    assign is_load     = (instr.r_fmt.opcode == OP_LOAD);
    assign mark_valid  = pop;
    assign mark_pd     = free_list[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_NUM_ARCH; i++) begin
                map_table[i] <= PHYS_W'(i);
            end
            for (int i = 0; i < NUM_FREE; i++) begin
                free_list[i] <= PHYS_W'(i + `OOO_NUM_ARCH);
            end
            head      <= '0;
            tail      <= PHYS_W'(NUM_FREE);
            count     <= (PHYS_W + 1)'(NUM_FREE);
            seq       <= '0;
            ren_valid <= 1'b0;
        end else begin
            if (pop) begin
                map_table[instr.r_fmt.rd] <= free_list[head];
                head <= head + 1'b1;
            end
            if (free_valid) begin
                free_list[tail] <= free_pd;
                tail <= tail + 1'b1;
            end
            if (pop && !free_valid) begin
                count <= count - 1'b1;
            end else if (free_valid && !pop) begin
                count <= count + 1'b1;
            end
            if (accept) begin
                ren_valid  <= 1'b1;
                seq        <= seq + 1'b1;
                ren.op     <= instr.r_fmt.opcode;
                ren.seq    <= seq;
                ren.rd     <= instr.r_fmt.rd;
                ren.pd     <= pop ? free_list[head] : '0;
                ren.old_pd <= map_table[instr.r_fmt.rd];   // map of r0 stays zero.
                ren.ps1    <= map_table[instr.r_fmt.rs1];
                ren.ps2    <= is_load ? '0 : map_table[instr.r_fmt.rs2];
                ren.imm    <= is_load ? {{(`OOO_XLEN - 19){instr.i_fmt.imm[18]}}, instr.i_fmt.imm}
                                      : '0;
            end else if (ren_ready) begin
                ren_valid <= 1'b0;
            end
        end
    end

    // register 0 is never handed out as a destination.
    assert property (@(posedge clk) disable iff (reset) pop |-> mark_pd != '0);
    // registers come back from the issue stage and must fit in the list.
    assert property (@(posedge clk) disable iff (reset) free_valid |-> count < `OOO_NUM_PHYS);

endmodule

/* physical_register_file.sv */
`timescale 1ns/100ps
`include "ooo_defines.svh"

module physical_register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  ooo_pkg::wb_t [3:0]     wb,
    input  logic                   mark_valid,
    input  logic [`OOO_PHYS_W-1:0] mark_pd,
    input  logic [`OOO_PHYS_W-1:0] rd_addr1,
    input  logic [`OOO_PHYS_W-1:0] rd_addr2,
    output logic [`OOO_XLEN-1:0]   rd_data1,
    output logic [`OOO_XLEN-1:0]   rd_data2,
    output logic                   rd_ready1,
    output logic                   rd_ready2
);
    localparam int XLEN = `OOO_XLEN;

    logic [XLEN-1:0]          regs [`OOO_NUM_PHYS];
    logic [`OOO_NUM_PHYS-1:0] valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_NUM_PHYS; i++) begin
                regs[i] <= (i < `OOO_NUM_ARCH) ? XLEN'(i) : '0;   // register i starts as value i.
            end
            valid <= '1;
        end else begin
            for (int p = 0; p < 4; p++) begin
                if (wb[p].valid && wb[p].pd != '0) begin   // register 0 stays zero.
                    regs[wb[p].pd]  <= wb[p].data;
                    valid[wb[p].pd] <= 1'b1;
                end
            end
            if (mark_valid && mark_pd != '0) begin
                valid[mark_pd] <= 1'b0;   // new destination waits for its result.
            end
        end
    end

    assign rd_data1  = regs[rd_addr1];
    assign rd_data2  = regs[rd_addr2];
    assign rd_ready1 = valid[rd_addr1];
    assign rd_ready2 = valid[rd_addr2];

    // each register has exactly one producer in flight, and only r0 maps to register 0.
    for (genvar p = 0; p < 4; p++) begin : g_port_chk
        assert property (@(posedge clk) disable iff (reset)
            wb[p].valid && wb[p].pd == '0 |-> wb[p].rd == '0);
        for (genvar q = p + 1; q < 4; q++) begin : g_pair_chk
            assert property (@(posedge clk) disable iff (reset)
                wb[p].valid && wb[q].valid && wb[p].pd != '0 |-> wb[p].pd != wb[q].pd);
        end
    end

endmodule

/* issue_stage.sv */
`timescale 1ns/100ps
`include "ooo_defines.svh"

module issue_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  ooo_pkg::renamed_t      ren,
    input  logic                   ren_valid,
    output logic                   ren_ready,
    output logic [`OOO_PHYS_W-1:0] rd_addr1,
    output logic [`OOO_PHYS_W-1:0] rd_addr2,
    input  logic [`OOO_XLEN-1:0]   rd_data1,
    input  logic [`OOO_XLEN-1:0]   rd_data2,
    input  logic                   rd_ready1,
    input  logic                   rd_ready2,
    output ooo_pkg::fu_req_t       mul_req,
    output logic                   mul_valid,
    input  logic                   mul_ready,
    output ooo_pkg::fu_req_t       div_req,
    output logic                   div_valid,
    input  logic                   div_ready,
    output ooo_pkg::fu_req_t       load_req,
    output logic                   load_valid,
    input  logic                   load_ready,
    output ooo_pkg::wb_t           wb_add,
    output logic                   free_valid,
    output logic [`OOO_PHYS_W-1:0] free_pd
);
    import ooo_pkg::*;

    renamed_t slot;
    logic     slot_valid;
    logic     is_imm;
    logic     operands_ok;
    logic     unit_ok;
    logic     dispatch;
    fu_req_t  req;

    assign rd_addr1    = slot.ps1;
    assign rd_addr2    = slot.ps2;
    assign is_imm      = (slot.op == OP_LOAD);
    assign operands_ok = rd_ready1 && (is_imm || rd_ready2);   // loads have no second source.

    always_comb begin
        case (slot.op)
            OP_MUL:  unit_ok = mul_ready;
            OP_DIV:  unit_ok = div_ready;
            OP_LOAD: unit_ok = load_ready;
            default: unit_ok = 1'b1;   // add and sub execute right here.
        endcase
    end

    assign dispatch  = slot_valid && operands_ok && unit_ok;
    assign ren_ready = !slot_valid || dispatch;

    assign req.seq = slot.seq;
    assign req.rd  = slot.rd;
    assign req.pd  = slot.pd;
    assign req.a   = rd_data1;
    assign req.b   = is_imm ? slot.imm : rd_data2;

    assign mul_req    = req;
    assign div_req    = req;
    assign load_req   = req;
    assign mul_valid  = dispatch && (slot.op == OP_MUL);
    assign div_valid  = dispatch && (slot.op == OP_DIV);
    assign load_valid = dispatch && (slot.op == OP_LOAD);

    // the old mapping has no readers left once this instruction has read its operands.
    assign free_valid = dispatch && (slot.rd != '0);
    assign free_pd    = slot.old_pd;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (ren_ready) begin
            slot_valid <= ren_valid;
        end
        if (ren_valid && ren_ready) begin
            slot <= ren;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_add.valid <= 1'b0;
        end else begin
            wb_add.valid <= dispatch && (slot.op == OP_ADD || slot.op == OP_SUB);
        end
        wb_add.seq  <= req.seq;
        wb_add.rd   <= req.rd;
        wb_add.pd   <= req.pd;
        wb_add.data <= (slot.op == OP_SUB) ? req.a - req.b : req.a + req.b;
    end

endmodule

/* int_multiplier.sv */
`timescale 1ns/100ps
`include "ooo_defines.svh"

module int_multiplier (
    input  logic             clk,
    input  logic             reset,
    input  ooo_pkg::fu_req_t req,
    input  logic             req_valid,
    output logic             req_ready,
    output ooo_pkg::wb_t     wb
);
    import ooo_pkg::*;

    localparam int STAGES = `OOO_MUL_STAGES;

    wb_t pipe [STAGES];

    assign req_ready = 1'b1;   // fully pipelined, one request per cycle.
    assign wb        = pipe[STAGES-1];

    always_ff @(posedge clk) begin
        pipe[0].valid <= req_valid;
        pipe[0].seq   <= req.seq;
        pipe[0].rd    <= req.rd;
        pipe[0].pd    <= req.pd;
        pipe[0].data  <= req.a * req.b;   // only the low word is kept.
        for (int s = 1; s < STAGES; s++) begin
            pipe[s] <= pipe[s-1];
        end
        if (reset) begin
            for (int s = 0; s < STAGES; s++) begin
                pipe[s].valid <= 1'b0;
            end
        end
    end

endmodule

/* int_divider.sv */
`timescale 1ns/100ps
`include "ooo_defines.svh"

module int_divider (
    input  logic             clk,
    input  logic             reset,
    input  ooo_pkg::fu_req_t req,
    input  logic             req_valid,
    output logic             req_ready,
    output ooo_pkg::wb_t     wb
);
    import ooo_pkg::*;

    localparam int XLEN  = `OOO_XLEN;
    localparam int CNT_W = $clog2(XLEN + 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    logic [XLEN-1:0]  rem;
    fu_req_t          op;   // a shifts from dividend to quotient, b is the divisor.
    logic [XLEN:0]    rem_shift;
    logic [XLEN+1:0]  diff;
    logic [XLEN-1:0]  quo_next;

    assign req_ready = !busy;
    assign rem_shift = {rem, op.a[XLEN-1]};
    assign diff      = {1'b0, rem_shift} - {2'b0, op.b};
    assign quo_next  = {op.a[XLEN-2:0], ~diff[XLEN+1]};   // a bit is set when the trial fits.

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= 1'b0;
            if (req_valid && !busy) begin
                busy  <= 1'b1;
                count <= CNT_W'(XLEN);
                rem   <= '0;
                op    <= req;
            end else if (busy) begin
                rem   <= diff[XLEN+1] ? rem_shift[XLEN-1:0] : diff[XLEN-1:0];
                op.a  <= quo_next;
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy     <= 1'b0;
                    wb.valid <= 1'b1;
                    wb.seq   <= op.seq;
                    wb.rd    <= op.rd;
                    wb.pd    <= op.pd;
                    wb.data  <= (op.b == '0) ? '1 : quo_next;   // divide by zero gives all ones.
                end
            end
        end
    end

    // the issue stage holds a divide back until this unit is idle again.
    assert property (@(posedge clk) disable iff (reset) busy |-> !req_valid);

endmodule

/* load_unit.sv */
`timescale 1ns/100ps
`include "ooo_defines.svh"

module load_unit (
    input  logic             clk,
    input  logic             reset,
    input  ooo_pkg::fu_req_t req,
    input  logic             req_valid,
    output logic             req_ready,
    output ooo_pkg::wb_t     wb
);
    import ooo_pkg::*;

    localparam int XLEN  = `OOO_XLEN;
    localparam int WORDS = `OOO_MEM_WORDS;
    localparam int IDX_W = $clog2(WORDS);

    logic [XLEN-1:0] mem [WORDS];
    wb_t             addr_q;   // data holds the byte address.

    assign req_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < WORDS; k++) begin
                mem[k] <= XLEN'(k) * `OOO_MEM_HASH;
            end
            addr_q.valid <= 1'b0;
            wb.valid     <= 1'b0;
        end else begin
            addr_q.valid <= req_valid;
            wb.valid     <= addr_q.valid;
        end
        addr_q.seq  <= req.seq;
        addr_q.rd   <= req.rd;
        addr_q.pd   <= req.pd;
        addr_q.data <= req.a + req.b;   // base plus sign-extended offset.
        wb.seq      <= addr_q.seq;
        wb.rd       <= addr_q.rd;
        wb.pd       <= addr_q.pd;
        wb.data     <= mem[addr_q.data[IDX_W+1:2]];   // word index wraps at memory size.
    end

endmodule

/* ooo_backend.sv */
`timescale 1ns/100ps
`include "ooo_defines.svh"

module ooo_backend (
    input  logic               clk,
    input  logic               reset,
    input  ooo_pkg::instr_u    instr,
    input  logic               instr_valid,
    output logic               instr_ready,
    output ooo_pkg::wb_t [3:0] wb
);
    import ooo_pkg::*;

    renamed_t               ren;
    logic                   ren_valid;
    logic                   ren_ready;
    logic                   mark_valid;
    logic [`OOO_PHYS_W-1:0] mark_pd;
    logic                   free_valid;
    logic [`OOO_PHYS_W-1:0] free_pd;
    logic [`OOO_PHYS_W-1:0] rd_addr1;
    logic [`OOO_PHYS_W-1:0] rd_addr2;
    logic [`OOO_XLEN-1:0]   rd_data1;
    logic [`OOO_XLEN-1:0]   rd_data2;
    logic                   rd_ready1;
    logic                   rd_ready2;
    fu_req_t                mul_req;
    logic                   mul_valid;
    logic                   mul_ready;
    fu_req_t                div_req;
    logic                   div_valid;
    logic                   div_ready;
    fu_req_t                load_req;
    logic                   load_valid;
    logic                   load_ready;

    rename_unit u_rename_unit (
        .clk, .reset, .instr, .instr_valid, .instr_ready, .ren, .ren_valid, .ren_ready,
        .mark_valid, .mark_pd, .free_valid, .free_pd
    );

    physical_register_file u_physical_register_file (
        .clk, .reset, .wb, .mark_valid, .mark_pd,
        .rd_addr1, .rd_addr2, .rd_data1, .rd_data2, .rd_ready1, .rd_ready2
    );

    issue_stage u_issue_stage (
        .clk, .reset, .ren, .ren_valid, .ren_ready,
        .rd_addr1, .rd_addr2, .rd_data1, .rd_data2, .rd_ready1, .rd_ready2,
        .mul_req, .mul_valid, .mul_ready, .div_req, .div_valid, .div_ready,
        .load_req, .load_valid, .load_ready,
        .wb_add(wb[FU_ADD]), .free_valid, .free_pd
    );

    int_multiplier u_int_multiplier (
        .clk, .reset, .req(mul_req), .req_valid(mul_valid), .req_ready(mul_ready),
        .wb(wb[FU_MUL])
    );

    int_divider u_int_divider (
        .clk, .reset, .req(div_req), .req_valid(div_valid), .req_ready(div_ready),
        .wb(wb[FU_DIV])
    );

    load_unit u_load_unit (
        .clk, .reset, .req(load_req), .req_valid(load_valid), .req_ready(load_ready),
        .wb(wb[FU_LOAD])
    );

endmodule

/* tb_ooo_backend.sv */
`timescale 1ns/100ps
`include "ooo_defines.svh"

module tb_ooo_backend;
    import ooo_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic       clk;
    logic       reset;
    instr_u     instr;
    logic       instr_valid;
    logic       instr_ready;
    wb_t [3:0]  wb;

    integer      seed = 32'h8030;
    logic [31:0] arch_regs [32];   // in-order architectural state.
    logic [7:0]  arch_map [32];    // in-order register mapping.
    logic [7:0]  free_regs [$];    // free physical registers in the order they are handed out.
    wb_t         exp_wb [256];     // expected completion, indexed by seq.
    bit          pending [256];
    int          issued;
    int          completed;
    bit          ooo_seen;         // set once a completion overtakes an older one.

    ooo_backend u_ooo_backend (
        .clk, .reset, .instr, .instr_valid, .instr_ready, .wb
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic instr_u make_reg_op(input op_e op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        instr_u in;
        in.r_fmt.opcode = op;
        in.r_fmt.rd     = rd;
        in.r_fmt.rs1    = rs1;
        in.r_fmt.rs2    = rs2;
        in.r_fmt.unused = '0;
        return in;
    endfunction

    function automatic instr_u make_load(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [18:0] imm);
        instr_u in;
        in.i_fmt.opcode = OP_LOAD;
        in.i_fmt.rd     = rd;
        in.i_fmt.rs1    = rs1;
        in.i_fmt.imm    = imm;
        return in;
    endfunction

    // executes one instruction in program order and returns its expected writeback.
    function automatic wb_t ref_execute(input instr_u in, input logic [7:0] seq);
        wb_t         exp;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [7:0]  k;
        exp       = '0;
        exp.valid = 1'b1;
        exp.seq   = seq;
        exp.rd    = in.r_fmt.rd;
        a = arch_regs[in.r_fmt.rs1];
        b = arch_regs[in.r_fmt.rs2];
        case (in.r_fmt.opcode)
            OP_ADD:  exp.data = a + b;
            OP_SUB:  exp.data = a - b;
            OP_MUL:  exp.data = a * b;
            OP_DIV:  exp.data = (b == 32'd0) ? '1 : a / b;
            default: begin
                addr     = a + {{13{in.i_fmt.imm[18]}}, in.i_fmt.imm};
                k        = addr[9:2];   // word index of the byte address.
                exp.data = 32'(k) * `OOO_MEM_HASH;
            end
        endcase
        if (in.r_fmt.rd != 5'd0) begin
            exp.pd = free_regs.pop_front();
            free_regs.push_back(arch_map[in.r_fmt.rd]);   // the old mapping is released later.
            arch_map[in.r_fmt.rd]  = exp.pd;
            arch_regs[in.r_fmt.rd] = exp.data;
        end
        return exp;
    endfunction

    task automatic check_bit(input logic got, input logic expected, input string name);
        if (got !== expected) begin
            report_failure($sformatf("error: %0t %s got %b expected %b",
                                     $time, name, got, expected));
        end
    endtask

    task automatic check_wb(input int port, input wb_t got);
        wb_t exp;
        if (!pending[got.seq]) begin
            report_failure($sformatf("wb[%0d] completed seq %0d, which is not outstanding",
                                     port, got.seq));
        end
        exp = exp_wb[got.seq];
        if (got.rd !== exp.rd) begin
            report_failure($sformatf("error: %0t wb[%0d].rd (seq %0d) got %0d expected %0d",
                                     $time, port, got.seq, got.rd, exp.rd));
        end
        if (got.pd !== exp.pd) begin
            report_failure($sformatf("error: %0t wb[%0d].pd (seq %0d) got %0d expected %0d",
                                     $time, port, got.seq, got.pd, exp.pd));
        end
        if (got.data !== exp.data) begin
            report_failure($sformatf("error: %0t wb[%0d].data (seq %0d) got %h expected %h",
                                     $time, port, got.seq, got.data, exp.data));
        end
        if (got.seq != 8'(completed)) begin
            ooo_seen = 1'b1;
        end
        pending[got.seq] = 1'b0;
        completed++;
    endtask

    // outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!reset) begin
            for (int p = 0; p < 4; p++) begin
                if (wb[p].valid) begin
                    check_wb(p, wb[p]);
                end
            end
        end
    end

    // called at posedge plus 1 ns, and returns at posedge plus 1 ns after the transfer.
    task automatic send_instr(input instr_u in);
        int         waited;
        logic [7:0] seq;
        seq    = 8'(issued);
        waited = 0;
        while (pending[seq]) begin   // the seq number is reused only once retired.
            if (waited == TIMEOUT_CYCLES) begin
                report_failure($sformatf("timeout: seq %0d never completed", seq));
            end
            waited++;
            step_cycle();
        end
        instr       = in;
        instr_valid = 1'b1;
        waited      = 0;
        @(negedge clk);
        while (!instr_ready) begin
            if (waited == TIMEOUT_CYCLES) begin
                report_failure("timeout: instr_ready stayed low with an instruction waiting");
            end
            waited++;
            @(negedge clk);
        end
        exp_wb[seq]  = ref_execute(in, seq);
        pending[seq] = 1'b1;
        issued++;
        step_cycle();
        instr_valid = 1'b0;
    endtask

    task automatic send_random(input int kind);
        logic [4:0] rd;
        rd = 5'(rand_below(32));
        case (kind)
            0, 1, 2: send_instr(make_reg_op(OP_ADD, rd, 5'(rand_below(32)), 5'(rand_below(32))));
            3:       send_instr(make_reg_op(OP_SUB, rd, 5'(rand_below(32)), 5'(rand_below(32))));
            4:       send_instr(make_reg_op(OP_MUL, rd, 5'(rand_below(32)), 5'(rand_below(32))));
            5:       send_instr(make_reg_op(OP_DIV, rd, 5'(rand_below(32)), 5'(rand_below(8))));
            default: send_instr(make_load(rd, 5'(rand_below(32)), 19'($random(seed))));
        endcase
    endtask

    initial begin
        int waited;
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        issued      = 0;
        completed   = 0;
        ooo_seen    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = 32'(i);
            arch_map[i]  = 8'(i);
        end
        for (int i = 32; i < 256; i++) begin
            free_regs.push_back(8'(i));
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // behavior 1: idle outputs after reset, then sums of the initial values.
        @(negedge clk);
        check_bit(instr_ready, 1'b1, "instr_ready");
        for (int p = 0; p < 4; p++) begin
            check_bit(wb[p].valid, 1'b0, $sformatf("wb[%0d].valid", p));
        end
        step_cycle();
        for (int i = 0; i < 8; i++) begin
            send_instr(make_reg_op(OP_ADD, 5'(20 + i), 5'(1 + i), 5'(9 + i)));
        end

        // behavior 2: dependent add/sub chains over a few registers.
        for (int i = 0; i < 40; i++) begin
            send_instr(make_reg_op(rand_below(2) ? OP_SUB : OP_ADD, 5'(1 + rand_below(6)),
                                   5'(1 + rand_below(6)), 5'(1 + rand_below(6))));
        end

        // behavior 3: slow divides overtaken by adds, divide by zero, back-to-back divides.
        send_instr(make_reg_op(OP_DIV, 5'd10, 5'd30, 5'd7));
        send_instr(make_reg_op(OP_ADD, 5'd12, 5'd1, 5'd2));
        send_instr(make_reg_op(OP_DIV, 5'd13, 5'd5, 5'd0));
        send_instr(make_reg_op(OP_DIV, 5'd14, 5'd20, 5'd3));
        send_instr(make_reg_op(OP_MUL, 5'd15, 5'd10, 5'd13));
        send_instr(make_reg_op(OP_MUL, 5'd16, 5'd8, 5'd9));
        for (int i = 0; i < 40; i++) begin
            send_random(rand_below(3) == 0 ? 0 : 4 + rand_below(2));
        end

        // behavior 4: loads with random bases and offsets.
        for (int i = 0; i < 30; i++) begin
            send_random(6);
        end

        // behavior 6: results aimed at r0 are reported but never kept.
        send_instr(make_reg_op(OP_ADD, 5'd0, 5'd1, 5'd2));
        send_instr(make_reg_op(OP_SUB, 5'd0, 5'd5, 5'd3));
        send_instr(make_reg_op(OP_ADD, 5'd4, 5'd0, 5'd0));
        send_instr(make_load(5'd6, 5'd0, 19'd8));

        // behavior 5: a long mixed stream that recycles every free register.
        for (int i = 0; i < 600; i++) begin
            send_random(rand_below(8));
            if (rand_below(4) == 0) begin
                repeat (rand_below(3)) step_cycle();
            end
        end

        waited = 0;
        while (completed != issued) begin
            if (waited == TIMEOUT_CYCLES) begin
                report_failure($sformatf("timeout: %0d of %0d instructions completed",
                                         completed, issued));
            end
            waited++;
            step_cycle();
        end
        if (!ooo_seen) begin
            report_failure("no instruction ever completed ahead of an older one");
        end else begin
            $display("%0d instructions completed", completed);
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* list.f */
+incdir+.
ooo_pkg.sv
rename_unit.sv
physical_register_file.sv
issue_stage.sv
int_multiplier.sv
int_divider.sv
load_unit.sv
ooo_backend.sv
tb_ooo_backend.sv

/* Bender.yml */
package:
  name: ooo_backend

sources:
  - include_dirs:
      - .
    files:
      - ooo_pkg.sv
      - rename_unit.sv
      - physical_register_file.sv
      - issue_stage.sv
      - int_multiplier.sv
      - int_divider.sv
      - load_unit.sv
      - ooo_backend.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ooo_backend.sv
